//--- Bender.yml
package:
  name: hyper_frontend

sources:
  - common/hyper_pkg.sv
  - rtl/hyper_cfg/hyper_cfg_regs.sv
  - rtl/hyper_cmd/hyper_addr_decode.sv
  - rtl/hyper_cmd/hyper_cmd_gen.sv
  - rtl/hyper_frontend_top.sv
  - target: test
    files:
      - test/hyper_frontend_chk.sv
      - test/tb_hyper_frontend.sv

//--- common/hyper_pkg.sv
/* HyperBus front end shared definitions
   Timing configuration, register bus, chip rule, transaction and command types */

package hyper_pkg;

    // Address map
    localparam int unsigned MaxChips        = 16;
    localparam int unsigned ChipIdxWidth    = $clog2(MaxChips);
    localparam int unsigned NumCfgRegs      = 8;    // Timing regs ahead of chip ranges
    localparam logic [31:0] ChipRangeStride = 32'h0040_0000;

    typedef struct packed {
        logic [3:0]  t_latency_access;
        logic        en_latency_additional;
        logic [15:0] t_burst_max;
        logic [3:0]  t_read_write_recovery;
        logic [3:0]  t_rx_clk_delay;
        logic [3:0]  t_tx_clk_delay;
        logic [3:0]  t_variable_latency_check;
        logic        address_space;
    } hyper_cfg_t;

    // Timing defaults after reset
    localparam hyper_cfg_t CfgRstVal = '{
        t_latency_access:         4'd6,
        en_latency_additional:    1'b1,
        t_burst_max:              16'd350,
        t_read_write_recovery:    4'd6,
        t_rx_clk_delay:           4'd8,
        t_tx_clk_delay:           4'd8,
        t_variable_latency_check: 4'd3,
        address_space:            1'b0
    };

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } reg_req_t;

    typedef struct packed {
        logic        ready;
        logic        error;
        logic [31:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic [ChipIdxWidth-1:0] idx;
        logic [31:0]             start_addr;    // Inclusive
        logic [31:0]             end_addr;      // Exclusive
    } chip_rule_t;

    typedef struct packed {
        logic [31:0] addr;     // Byte address
        logic        write;
        logic [15:0] len;      // Words
    } txn_t;

    typedef struct packed {
        logic [47:0]             ca;
        logic [ChipIdxWidth-1:0] chip_idx;
        logic [4:0]              latency;
        logic [15:0]             len;
        logic                    decode_err;
    } cmd_t;

endpackage

//--- rtl/hyper_cfg/hyper_cfg_regs.sv
/* HyperBus configuration register file
   Timing fields and per-chip address ranges behind a valid/ready register bus */

`timescale 1ns/1ps

module hyper_cfg_regs #(
    parameter int unsigned NumChips = 4
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  hyper_pkg::reg_req_t                   reg_req_i,
    output hyper_pkg::reg_rsp_t                   reg_rsp_o,
    output hyper_pkg::hyper_cfg_t                 cfg_o,
    output hyper_pkg::chip_rule_t [NumChips-1:0]  chip_rules_o
);

    localparam int unsigned NumRegs = hyper_pkg::NumCfgRegs + 2 * NumChips;

    hyper_pkg::hyper_cfg_t           cfg_d, cfg_q;
    logic [NumChips-1:0][1:0][31:0]  crange_d, crange_q;   // [chip][0 start, 1 end]

    logic [29:0]  sel_word;
    logic         sel_mapped;
    logic         wr_en;
    logic [31:0]  wmask;
    logic [31:0]  rd_val;
    logic [31:0]  merged;

    assign sel_word   = reg_req_i.addr[31:2];
    assign sel_mapped = (sel_word < 30'(NumRegs));
    assign wr_en      = reg_req_i.valid & reg_req_i.write & sel_mapped;

    // Byte strobes widened to a bit mask
    assign wmask = {{8{reg_req_i.wstrb[3]}}, {8{reg_req_i.wstrb[2]}},
                    {8{reg_req_i.wstrb[1]}}, {8{reg_req_i.wstrb[0]}}};

    always_comb begin : proc_read
        rd_val = '0;
        if (sel_mapped) begin
            case (sel_word)
                30'd0: rd_val = 32'(cfg_q.t_latency_access);
                30'd1: rd_val = 32'(cfg_q.en_latency_additional);
                30'd2: rd_val = 32'(cfg_q.t_burst_max);
                30'd3: rd_val = 32'(cfg_q.t_read_write_recovery);
                30'd4: rd_val = 32'(cfg_q.t_rx_clk_delay);
                30'd5: rd_val = 32'(cfg_q.t_tx_clk_delay);
                30'd6: rd_val = 32'(cfg_q.t_variable_latency_check);
                30'd7: rd_val = 32'(cfg_q.address_space);
                default: begin
                    for (int unsigned i = 0; i < NumChips; i++) begin
                        if (sel_word == 30'(hyper_pkg::NumCfgRegs + 2 * i)) begin
                            rd_val = crange_q[i][0];
                        end
                        if (sel_word == 30'(hyper_pkg::NumCfgRegs + 2 * i + 1)) begin
                            rd_val = crange_q[i][1];
                        end
                    end
                end
            endcase
        end
    end

    // Old value is the zero-extended read, so one merge serves every register
    assign merged = (rd_val & ~wmask) | (reg_req_i.wdata & wmask);

    always_comb begin : proc_write
        cfg_d    = cfg_q;
        crange_d = crange_q;
        if (wr_en) begin
            case (sel_word)
                30'd0: cfg_d.t_latency_access         = merged[3:0];
                30'd1: cfg_d.en_latency_additional    = merged[0];
                30'd2: cfg_d.t_burst_max              = merged[15:0];
                30'd3: cfg_d.t_read_write_recovery    = merged[3:0];
                30'd4: cfg_d.t_rx_clk_delay           = merged[3:0];
                30'd5: cfg_d.t_tx_clk_delay           = merged[3:0];
                30'd6: cfg_d.t_variable_latency_check = merged[3:0];
                30'd7: cfg_d.address_space            = merged[0];
                default: begin
                    for (int unsigned i = 0; i < NumChips; i++) begin
                        if (sel_word == 30'(hyper_pkg::NumCfgRegs + 2 * i)) begin
                            crange_d[i][0] = merged;
                        end
                        if (sel_word == 30'(hyper_pkg::NumCfgRegs + 2 * i + 1)) begin
                            crange_d[i][1] = merged;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin : proc_regs
        if (!rst_n_i) begin
            cfg_q <= hyper_pkg::CfgRstVal;
            for (int unsigned i = 0; i < NumChips; i++) begin
                crange_q[i][0] <= 32'(i) * hyper_pkg::ChipRangeStride;
                crange_q[i][1] <= 32'(i + 1) * hyper_pkg::ChipRangeStride;   // End is exclusive
            end
        end else begin
            cfg_q    <= cfg_d;
            crange_q <= crange_d;
        end
    end

    assign reg_rsp_o.ready = 1'b1;                          // Single-cycle access
    assign reg_rsp_o.error = reg_req_i.valid & ~sel_mapped;
    assign reg_rsp_o.rdata = rd_val;

    assign cfg_o = cfg_q;

    for (genvar i = 0; i < NumChips; i++) begin : gen_rules
        assign chip_rules_o[i].idx        = hyper_pkg::ChipIdxWidth'(i);   // Position is identity
        assign chip_rules_o[i].start_addr = crange_q[i][0];
        assign chip_rules_o[i].end_addr   = crange_q[i][1];
    end

endmodule

//--- rtl/hyper_cmd/hyper_addr_decode.sv
/* Chip address decoder
   First matching chip rule wins; returns chip index and offset into that chip */

`timescale 1ns/1ps

module hyper_addr_decode #(
    parameter int unsigned NumChips = 4
) (
    input  logic [31:0]                           addr_i,
    input  hyper_pkg::chip_rule_t [NumChips-1:0]  chip_rules_i,
    output logic                                  hit_o,
    output logic [hyper_pkg::ChipIdxWidth-1:0]    chip_idx_o,
    output logic [31:0]                           offset_o
);

    logic [NumChips-1:0] match;
    logic [31:0]         sel_start;

    // All range checks in parallel
    for (genvar i = 0; i < NumChips; i++) begin : gen_match
        assign match[i] = (addr_i >= chip_rules_i[i].start_addr) &&
                          (addr_i <  chip_rules_i[i].end_addr);
    end

    always_comb begin : proc_select
        logic found;
        found      = 1'b0;
        chip_idx_o = '0;
        sel_start  = '0;
        for (int unsigned i = 0; i < NumChips; i++) begin
            if (match[i] && !found) begin   // Lowest index has priority
                found      = 1'b1;
                chip_idx_o = chip_rules_i[i].idx;
                sel_start  = chip_rules_i[i].start_addr;
            end
        end
        hit_o = found;
    end

    // Miss leaves sel_start at zero, so force the offset too
    assign offset_o = hit_o ? (addr_i - sel_start) : '0;

endmodule

//--- rtl/hyper_cmd/hyper_cmd_gen.sv
/* HyperBus command generator
   Decodes transactions into command-address records behind a one-entry output stage */

`timescale 1ns/1ps

module hyper_cmd_gen #(
    parameter int unsigned NumChips = 4
) (
    input  logic                                  clk_i,
    input  logic                                  rst_n_i,
    input  hyper_pkg::hyper_cfg_t                 cfg_i,
    input  hyper_pkg::chip_rule_t [NumChips-1:0]  chip_rules_i,
    input  logic                                  txn_valid_i,
    output logic                                  txn_ready_o,
    input  hyper_pkg::txn_t                       txn_i,
    output logic                                  cmd_valid_o,
    input  logic                                  cmd_ready_i,
    output hyper_pkg::cmd_t                       cmd_o
);

    logic                                dec_hit;
    logic [hyper_pkg::ChipIdxWidth-1:0]  dec_chip_idx;
    logic [31:0]                         dec_offset;

    hyper_pkg::cmd_t  cmd_d, cmd_q;
    logic             cmd_valid_q;
    logic             accept;

    hyper_addr_decode #(
        .NumChips     ( NumChips     )
    ) u_decode (
        .addr_i       ( txn_i.addr   ),
        .chip_rules_i ( chip_rules_i ),
        .hit_o        ( dec_hit      ),
        .chip_idx_o   ( dec_chip_idx ),
        .offset_o     ( dec_offset   )
    );

    always_comb begin : proc_build
        logic [31:0] word_addr;
        word_addr = dec_offset >> 1;    // Device is 16-bit addressed
        cmd_d     = '0;
        cmd_d.len = txn_i.len;
        if (cfg_i.en_latency_additional) begin
            cmd_d.latency = {cfg_i.t_latency_access, 1'b0};
        end else begin
            cmd_d.latency = {1'b0, cfg_i.t_latency_access};
        end
        if (dec_hit) begin
            cmd_d.ca[47]    = ~txn_i.write;          // Read flag
            cmd_d.ca[46]    = cfg_i.address_space;
            cmd_d.ca[45]    = 1'b1;                  // Linear burst
            cmd_d.ca[44:16] = word_addr[31:3];       // Row and upper column
            cmd_d.ca[2:0]   = word_addr[2:0];        // Lower column
            cmd_d.chip_idx  = dec_chip_idx;
        end else begin
            cmd_d.decode_err = 1'b1;
        end
    end

    // Stage can take a new entry when empty or draining this cycle
    assign txn_ready_o = ~cmd_valid_q | cmd_ready_i;
    assign accept      = txn_valid_i & txn_ready_o;

    always_ff @(posedge clk_i) begin : proc_valid
        if (!rst_n_i) begin
            cmd_valid_q <= 1'b0;
        end else if (txn_ready_o) begin
            cmd_valid_q <= txn_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : proc_payload
        if (accept) begin
            cmd_q <= cmd_d;
        end
    end

    assign cmd_valid_o = cmd_valid_q;
    assign cmd_o       = cmd_q;

endmodule

//--- rtl/hyper_frontend_top.sv
/* HyperBus front end top level
   Register file feeding the command generator with timing and chip ranges */

`timescale 1ns/1ps

module hyper_frontend_top #(
    parameter int unsigned NumChips = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  hyper_pkg::reg_req_t  reg_req_i,
    output hyper_pkg::reg_rsp_t  reg_rsp_o,
    input  logic                 txn_valid_i,
    output logic                 txn_ready_o,
    input  hyper_pkg::txn_t      txn_i,
    output logic                 cmd_valid_o,
    input  logic                 cmd_ready_i,
    output hyper_pkg::cmd_t      cmd_o
);

    hyper_pkg::hyper_cfg_t                 cfg;
    hyper_pkg::chip_rule_t [NumChips-1:0]  chip_rules;

    hyper_cfg_regs #(
        .NumChips     ( NumChips   )
    ) u_cfg_regs (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .reg_req_i    ( reg_req_i  ),
        .reg_rsp_o    ( reg_rsp_o  ),
        .cfg_o        ( cfg        ),
        .chip_rules_o ( chip_rules )
    );

    // Config is sampled per transaction inside the generator
    hyper_cmd_gen #(
        .NumChips     ( NumChips    )
    ) u_cmd_gen (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .cfg_i        ( cfg         ),
        .chip_rules_i ( chip_rules  ),
        .txn_valid_i  ( txn_valid_i ),
        .txn_ready_o  ( txn_ready_o ),
        .txn_i        ( txn_i       ),
        .cmd_valid_o  ( cmd_valid_o ),
        .cmd_ready_i  ( cmd_ready_i ),
        .cmd_o        ( cmd_o       )
    );

endmodule

//--- tb.f
common/hyper_pkg.sv
rtl/hyper_cfg/hyper_cfg_regs.sv
rtl/hyper_cmd/hyper_addr_decode.sv
rtl/hyper_cmd/hyper_cmd_gen.sv
rtl/hyper_frontend_top.sv
test/hyper_frontend_chk.sv
test/tb_hyper_frontend.sv

//--- test/hyper_frontend_chk.sv
/* Bound protocol checker for the HyperBus front end
   Command stability, reset state and register error qualification */

`timescale 1ns/1ps

module hyper_frontend_chk (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input hyper_pkg::reg_req_t  reg_req_i,
    input hyper_pkg::reg_rsp_t  reg_rsp_i,
    input logic                 cmd_valid_i,
    input logic                 cmd_ready_i,
    input hyper_pkg::cmd_t      cmd_i
);

    int unsigned fail_cnt = 0;    // Summed into the testbench error count

    // Record must hold while the consumer stalls
    a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cmd_valid_i && !cmd_ready_i) |=> $stable(cmd_i))
    else begin
        $error("cmd_o changed while cmd_ready_i was low");
        fail_cnt++;
    end

    a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |=> !cmd_valid_i)
    else begin
        $error("cmd_valid_o high right after reset");
        fail_cnt++;
    end

    a_err_qual: assert property (@(posedge clk_i) reg_rsp_i.error |-> reg_req_i.valid)
    else begin
        $error("register error without a request");
        fail_cnt++;
    end

endmodule

bind hyper_frontend_top hyper_frontend_chk u_chk (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .reg_req_i   ( reg_req_i   ),
    .reg_rsp_i   ( reg_rsp_o   ),
    .cmd_valid_i ( cmd_valid_o ),
    .cmd_ready_i ( cmd_ready_i ),
    .cmd_i       ( cmd_o       )
);

//--- test/tb_hyper_frontend.sv
/* HyperBus front end testbench
   Directed register, decode and back-pressure tests against a register-state model */

`timescale 1ns/1ps

module tb_hyper_frontend;

    localparam int unsigned NumChips      = 4;
    localparam int unsigned NumRegs       = 16;
    localparam int unsigned TimeoutCycles = 50;

    logic                 clk, rst_n;
    hyper_pkg::reg_req_t  reg_req;
    hyper_pkg::reg_rsp_t  reg_rsp;
    logic                 txn_valid, txn_ready, cmd_valid, cmd_ready;
    hyper_pkg::txn_t      txn;
    hyper_pkg::cmd_t      cmd;

    logic [31:0]      shadow [NumRegs];    // Expected register contents
    hyper_pkg::cmd_t  exp_q [$];
    hyper_pkg::cmd_t  rcv_q [$];
    int unsigned      rcv_cycle_q [$];
    int unsigned      cycle_cnt = 0;
    int unsigned      err_cnt   = 0;
    int unsigned      test_cnt  = 0;
    int unsigned      check_cnt = 0;
    logic [31:0]      rng_state;

    hyper_frontend_top #(
        .NumChips    ( NumChips  )
    ) u_dut (
        .clk_i       ( clk       ),
        .rst_n_i     ( rst_n     ),
        .reg_req_i   ( reg_req   ),
        .reg_rsp_o   ( reg_rsp   ),
        .txn_valid_i ( txn_valid ),
        .txn_ready_o ( txn_ready ),
        .txn_i       ( txn       ),
        .cmd_valid_o ( cmd_valid ),
        .cmd_ready_i ( cmd_ready ),
        .cmd_o       ( cmd       )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Record every command handed over at the next edge
    always @(negedge clk) begin
        if (rst_n && cmd_valid && cmd_ready) begin
            rcv_q.push_back(cmd);
            rcv_cycle_q.push_back(cycle_cnt);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] field_mask(input int unsigned idx);
        case (idx)
            0, 3, 4, 5, 6: return 32'h0000_000F;
            1, 7:          return 32'h0000_0001;
            2:             return 32'h0000_FFFF;
            default:       return 32'hFFFF_FFFF;    // Chip range words
        endcase
    endfunction

    // Expected command from the transaction and the register copy
    function automatic hyper_pkg::cmd_t model_cmd(input hyper_pkg::txn_t t);
        hyper_pkg::cmd_t c;
        logic [31:0]     word;
        logic            found;
        c         = '0;
        found     = 1'b0;
        c.len     = t.len;
        c.latency = shadow[1][0] ? 5'(shadow[0][3:0]) * 5'd2 : 5'(shadow[0][3:0]);
        for (int i = 0; i < NumChips; i++) begin
            if (!found && t.addr >= shadow[8 + 2 * i] && t.addr < shadow[9 + 2 * i]) begin
                found      = 1'b1;
                word       = (t.addr - shadow[8 + 2 * i]) >> 1;
                c.chip_idx = 4'(i);
                c.ca       = {~t.write, shadow[7][0], 1'b1, word[31:3], 13'd0, word[2:0]};
            end
        end
        c.decode_err = ~found;
        return c;
    endfunction

    task automatic abort_run(input string what);
        $display("ERROR: timed out waiting for %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic reg_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata,
                              output logic err);
        int unsigned timer;
        timer = 0;
        @(posedge clk);
        #2;
        reg_req = '{valid: 1'b1, write: wr, addr: addr, wdata: wdata, wstrb: wstrb};
        @(negedge clk);
        while (!reg_rsp.ready && timer < TimeoutCycles) begin
            @(negedge clk);
            timer++;
        end
        if (!reg_rsp.ready) begin
            abort_run("register bus ready");
        end else begin
            rdata = reg_rsp.rdata;
            err   = reg_rsp.error;
            @(posedge clk);
            #2;
            reg_req.valid = 1'b0;
        end
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
        logic [31:0] rdata;
        logic [31:0] mask;
        logic        err;
        int unsigned idx;
        idx  = addr[31:2];
        mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
        reg_access(1'b1, addr, wdata, wstrb, rdata, err);
        check_val("reg_rsp_o.error", 64'(err), 64'(idx >= NumRegs));
        if (idx < NumRegs) begin
            shadow[idx] = ((shadow[idx] & ~mask) | (wdata & mask)) & field_mask(idx);
        end
    endtask

    task automatic reg_read(input logic [31:0] addr);
        logic [31:0] rdata;
        logic        err;
        int unsigned idx;
        idx = addr[31:2];
        reg_access(1'b0, addr, 32'h0, 4'h0, rdata, err);
        check_val("reg_rsp_o.error", 64'(err), 64'(idx >= NumRegs));
        check_val("reg_rsp_o.rdata", 64'(rdata), (idx < NumRegs) ? 64'(shadow[idx]) : 64'h0);
    endtask

    task automatic send_txn(input logic [31:0] addr, input logic wr, input logic [15:0] len);
        int unsigned timer;
        timer = 0;
        @(posedge clk);
        #2;
        txn_valid = 1'b1;
        txn       = '{addr: addr, write: wr, len: len};
        @(negedge clk);
        while (!txn_ready && timer < TimeoutCycles) begin
            @(negedge clk);
            timer++;
        end
        if (!txn_ready) begin
            abort_run("txn_ready_o");
        end else begin
            exp_q.push_back(model_cmd(txn));    // Config as seen at acceptance
            @(posedge clk);
            #2;
            txn_valid = 1'b0;
        end
    endtask

    task automatic expect_cmd(output int unsigned stamp);
        hyper_pkg::cmd_t got, exp;
        int unsigned     timer;
        timer = 0;
        stamp = 0;
        while (rcv_q.size() == 0 && timer < TimeoutCycles) begin
            @(negedge clk);
            timer++;
        end
        if (rcv_q.size() == 0) begin
            abort_run("a command on cmd_o");
        end else if (exp_q.size() == 0) begin
            $display("ERROR: command arrived with no transaction pending");
            err_cnt++;
            void'(rcv_q.pop_front());
            void'(rcv_cycle_q.pop_front());
        end else begin
            got   = rcv_q.pop_front();
            stamp = rcv_cycle_q.pop_front();
            exp   = exp_q.pop_front();
            check_val("cmd_o.chip_idx", 64'(got.chip_idx), 64'(exp.chip_idx));
            check_val("cmd_o.ca", 64'(got.ca), 64'(exp.ca));
            check_val("cmd_o.latency", 64'(got.latency), 64'(exp.latency));
            check_val("cmd_o.len", 64'(got.len), 64'(exp.len));
            check_val("cmd_o.decode_err", 64'(got.decode_err), 64'(exp.decode_err));
        end
    endtask

    task automatic end_test(input string name, input int unsigned err_start);
        test_cnt++;
        $display("Test %0d %s done, %0d errors", test_cnt, name, err_cnt - err_start);
    endtask

    task automatic test_reset_values();
        int unsigned e0;
        e0 = err_cnt;
        check_val("cmd_valid_o", 64'(cmd_valid), 64'h0);
        check_val("txn_ready_o", 64'(txn_ready), 64'h1);
        check_val("reg_rsp_o.error", 64'(reg_rsp.error), 64'h0);
        for (int i = 0; i < NumRegs; i++) begin
            reg_read(32'(i) * 4);
        end
        end_test("reset values", e0);
    endtask

    task automatic test_reg_access();
        int unsigned e0;
        e0 = err_cnt;
        reg_write(32'h08, 32'hAABB_CCDD, 4'b0010);    // Byte 1 of t_burst_max only
        reg_read(32'h08);
        reg_write(32'h0C, 32'hFFFF_FFFA, 4'hF);       // Truncated to 4 bits
        reg_read(32'h0C);
        reg_write(32'h3C, 32'h00FF_0000, 4'b0100);    // Chip 3 end, byte 2
        reg_read(32'h3C);
        reg_write(32'h40, 32'hFFFF_FFFF, 4'hF);       // Index 16 is past the map
        reg_read(32'h40);
        reg_read(32'h00);
        end_test("register access", e0);
    endtask

    task automatic test_random_cmds();
        int unsigned e0, stamp;
        e0 = err_cnt;
        for (int i = 0; i < 25; i++) begin
            if (i == 20) begin
                reg_write(32'h00, 32'h5, 4'hF);
                reg_write(32'h04, 32'h0, 4'hF);    // No additional latency
            end
            rng_state = xorshift32(rng_state);
            send_txn({8'h00, rng_state[23:0]}, rng_state[24], 16'(rng_state[31:25]) + 16'd1);
            expect_cmd(stamp);
        end
        end_test("random commands", e0);
    endtask

    task automatic test_remap();
        int unsigned e0, stamp;
        e0 = err_cnt;
        reg_write(32'h28, 32'h0200_0000, 4'hF);
        reg_write(32'h2C, 32'h0300_0000, 4'hF);
        send_txn(32'h0200_0000, 1'b0, 16'd4);
        expect_cmd(stamp);
        send_txn(32'h02AB_CDE6, 1'b1, 16'd8);
        expect_cmd(stamp);
        send_txn(32'h0050_0000, 1'b0, 16'd1);    // Old chip 1 window now unmapped
        expect_cmd(stamp);
        send_txn(32'h5000_0000, 1'b0, 16'd2);
        expect_cmd(stamp);
        end_test("chip remap", e0);
    endtask

    task automatic test_backpressure();
        int unsigned e0, timer;
        int unsigned stamps [3];
        e0 = err_cnt;
        @(posedge clk);
        #2;
        cmd_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    send_txn(32'h0080_0000 + 32'(i) * 32'h100, i[0], 16'(i + 1));
                end
            end
            begin
                timer = 0;
                @(negedge clk);
                while (!cmd_valid && timer < TimeoutCycles) begin
                    @(negedge clk);
                    timer++;
                end
                if (!cmd_valid) begin
                    abort_run("cmd_valid_o while stalled");
                end else begin
                    repeat (4) begin
                        @(negedge clk);
                        check_val("txn_ready_o", 64'(txn_ready), 64'h0);
                    end
                    @(posedge clk);
                    #2;
                    cmd_ready = 1'b1;
                end
            end
        join
        for (int i = 0; i < 3; i++) begin
            expect_cmd(stamps[i]);
        end
        check_val("cmd handover spacing", 64'(stamps[1] - stamps[0]), 64'h1);
        // Give a repeated last command time to show up
        repeat (2) @(negedge clk);
        check_val("leftover commands", 64'(rcv_q.size() + exp_q.size()), 64'h0);
        end_test("back-pressure", e0);
    endtask

    initial begin
        rst_n     = 1'b0;
        reg_req   = '0;
        txn_valid = 1'b0;
        txn       = '0;
        cmd_ready = 1'b1;
        rng_state = 32'h6998;
        shadow[0] = 32'd6;
        shadow[1] = 32'd1;
        shadow[2] = 32'd350;
        shadow[3] = 32'd6;
        shadow[4] = 32'd8;
        shadow[5] = 32'd8;
        shadow[6] = 32'd3;
        shadow[7] = 32'd0;
        for (int i = 0; i < NumChips; i++) begin
            shadow[8 + 2 * i] = 32'(i) * 32'h0040_0000;
            shadow[9 + 2 * i] = 32'(i + 1) * 32'h0040_0000;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_values();
        test_reg_access();
        test_random_cmds();
        test_remap();
        test_backpressure();
        err_cnt += u_dut.u_chk.fail_cnt;    // Assertion failures count as errors
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
